// File: Makefile
TOP := cp0Tb

.PHONY: all lint clean

# Build, run, and pass only if the testbench reports success
all:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qF "=== PASS ==="

lint:
	verilator --lint-only --timing -Wall --top-module cp0Top -f list.f

clean:
	rm -rf obj_dir

// File: list.f
rtl/cp0Pkg.sv
rtl/cp0Control.sv
rtl/cp0Regs.sv
rtl/jointTlb.sv
rtl/cp0Top.sv
sim/cp0Tb.sv

// File: rtl/cp0Control.sv
`timescale 1ns/10ps

module cp0Control (
    input  logic         clk,
    input  logic         rst,
    input  logic         req,
    input  cp0Pkg::cp0Op op,
    output logic         ack,
    output logic         writeEn,
    output logic         excEn,
    output logic         eretEn,
    output logic         tlbReadEn,
    output logic         tlbProbeEn,
    output logic         tlbWriteEn,
    output logic         useRandom,
    output logic         captureEn
);

    cp0Pkg::ctrlState state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= cp0Pkg::stIdle;
            ack        <= 1'b0;
            writeEn    <= 1'b0;
            excEn      <= 1'b0;
            eretEn     <= 1'b0;
            tlbReadEn  <= 1'b0;
            tlbProbeEn <= 1'b0;
            tlbWriteEn <= 1'b0;
            useRandom  <= 1'b0;
            captureEn  <= 1'b0;
        end else begin
            // Strobes are single cycle pulses
            writeEn    <= 1'b0;
            excEn      <= 1'b0;
            eretEn     <= 1'b0;
            tlbReadEn  <= 1'b0;
            tlbProbeEn <= 1'b0;
            tlbWriteEn <= 1'b0;
            useRandom  <= 1'b0;
            captureEn  <= 1'b0;
            case (state)
                cp0Pkg::stIdle: begin
                    if (req) begin
                        state      <= cp0Pkg::stExec;
                        writeEn    <= op == cp0Pkg::opMtc0;
                        excEn      <= op == cp0Pkg::opExc;
                        eretEn     <= op == cp0Pkg::opEret;
                        tlbReadEn  <= op == cp0Pkg::opTlbr;
                        tlbProbeEn <= op == cp0Pkg::opTlbp;
                        tlbWriteEn <= op == cp0Pkg::opTlbwi || op == cp0Pkg::opTlbwr;
                        useRandom  <= op == cp0Pkg::opTlbwr;
                    end
                end
                cp0Pkg::stExec: begin
                    state     <= cp0Pkg::stAck;
                    captureEn <= 1'b1;  // Registers settled, sample result
                end
                cp0Pkg::stAck: begin
                    ack <= req;
                    if (!req) begin
                        state <= cp0Pkg::stIdle;
                    end
                end
                default: state <= cp0Pkg::stIdle;
            endcase
        end
    end

endmodule

// File: rtl/cp0Pkg.sv
package cp0Pkg;

    typedef enum logic [2:0] {
        opMfc0, opMtc0, opTlbr, opTlbwi, opTlbwr, opTlbp, opExc, opEret
    } cp0Op;

    typedef enum logic [1:0] {
        stIdle, stExec, stAck
    } ctrlState;

    // Register number in [7:3], select in [2:0]
    localparam logic [7:0] regIndex    = {5'd0, 3'd0};
    localparam logic [7:0] regRandom   = {5'd1, 3'd0};
    localparam logic [7:0] regEntryLo0 = {5'd2, 3'd0};
    localparam logic [7:0] regEntryLo1 = {5'd3, 3'd0};
    localparam logic [7:0] regContext  = {5'd4, 3'd0};
    localparam logic [7:0] regWired    = {5'd6, 3'd0};
    localparam logic [7:0] regBadVAddr = {5'd8, 3'd0};
    localparam logic [7:0] regEntryHi  = {5'd10, 3'd0};
    localparam logic [7:0] regStatus   = {5'd12, 3'd0};
    localparam logic [7:0] regCause    = {5'd13, 3'd0};
    localparam logic [7:0] regEpc      = {5'd14, 3'd0};
    localparam logic [7:0] regPrid     = {5'd15, 3'd0};
    localparam logic [7:0] regEbase    = {5'd15, 3'd1};
    localparam logic [7:0] regConfig   = {5'd16, 3'd0};
    localparam logic [7:0] regConfig1  = {5'd16, 3'd1};

    localparam int tlbEntries = 8;
    localparam int tlbIndexW  = 3;
    localparam int tlbEntryW  = 86;   // VPN2, G, ASID, even page, odd page

    localparam logic [31:0] statusReset  = 32'h1040_0004;  // CU0, BEV, ERL
    localparam logic [31:0] ebaseReset   = 32'h8000_0000;
    localparam logic [31:0] pridValue    = 32'h0001_8000;
    localparam logic [31:0] configReset  = 32'h8000_0083;  // M, MT = TLB, K0 = 3
    localparam logic [31:0] config1Reset = 32'h0e00_0000;  // MMU size 8

    // Writable bits for MTC0
    localparam logic [31:0] indexMask   = 32'h0000_0007;
    localparam logic [31:0] entryLoMask = 32'h3fff_ffff;
    localparam logic [31:0] contextMask = 32'hff80_0000;
    localparam logic [31:0] wiredMask   = 32'h0000_0007;
    localparam logic [31:0] entryHiMask = 32'hffff_e0ff;
    localparam logic [31:0] statusMask  = 32'h1040_ff17;
    localparam logic [31:0] causeMask   = 32'h0000_0300;
    localparam logic [31:0] ebaseMask   = 32'h3fff_f000;
    localparam logic [31:0] configMask  = 32'h0000_0007;

    localparam int statusExl = 1;
    localparam int statusIe  = 0;

endpackage

// File: rtl/cp0Regs.sv
`timescale 1ns/10ps

module cp0Regs (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [7:0]                     addr,
    input  logic [31:0]                    wdata,
    input  logic                           writeEn,
    input  logic                           excEn,
    input  logic                           eretEn,
    input  logic                           tlbReadEn,
    input  logic                           tlbProbeEn,
    input  logic                           useRandom,
    input  logic                           captureEn,
    input  logic [4:0]                     excCode,
    input  logic [31:0]                    excBadVAddr,
    input  logic                           excBd,
    input  logic [31:0]                    excEpc,
    input  logic [5:0]                     hint,
    input  logic [cp0Pkg::tlbEntryW-1:0]   readEntry,
    input  logic                           probeHit,
    input  logic [cp0Pkg::tlbIndexW-1:0]   probeIndex,
    output logic [31:0]                    rdata,
    output logic [cp0Pkg::tlbEntryW-1:0]   entryOut,
    output logic [cp0Pkg::tlbIndexW-1:0]   writeIndex,
    output logic [7:0]                     asid,
    output logic                           userMode,
    output logic                           exlSet,
    output logic                           interruptPending,
    output logic [31:0]                    epcAddress,
    output logic [31:0]                    ebaseAddress
);

    logic [31:0]                  indexReg;
    logic [cp0Pkg::tlbIndexW-1:0] randomReg;
    logic [31:0]                  entryLo0;
    logic [31:0]                  entryLo1;
    logic [31:0]                  contextReg;
    logic [31:0]                  wiredReg;
    logic [31:0]                  badVAddr;
    logic [31:0]                  entryHi;
    logic [31:0]                  status;
    logic [31:0]                  cause;
    logic [31:0]                  epc;
    logic [31:0]                  ebase;
    logic [31:0]                  configReg;
    logic [7:0]                   selAddr;   // Register returned at capture
    logic [31:0]                  readValue;

    function automatic logic [31:0] merge(input logic [31:0] oldVal,
                                          input logic [31:0] newVal,
                                          input logic [31:0] mask);
        return (oldVal & ~mask) | (newVal & mask);
    endfunction

    assign writeIndex       = useRandom ? randomReg : indexReg[cp0Pkg::tlbIndexW-1:0];
    assign asid             = entryHi[7:0];
    // G is stored once, set only when both halves are global
    assign entryOut         = {entryHi[31:13], entryLo0[0] & entryLo1[0], entryHi[7:0],
                               entryLo0[29:1], entryLo1[29:1]};
    assign userMode         = status[4:1] == 4'b1000;
    assign exlSet           = status[cp0Pkg::statusExl];
    assign interruptPending = status[cp0Pkg::statusIe] && !status[cp0Pkg::statusExl]
                              && |(status[15:8] & cause[15:8]);
    assign epcAddress       = epc;
    assign ebaseAddress     = ebase;

    always_comb begin
        case (selAddr)
            cp0Pkg::regIndex:    readValue = indexReg;
            cp0Pkg::regRandom:   readValue = {29'd0, randomReg};
            cp0Pkg::regEntryLo0: readValue = entryLo0;
            cp0Pkg::regEntryLo1: readValue = entryLo1;
            cp0Pkg::regContext:  readValue = contextReg;
            cp0Pkg::regWired:    readValue = wiredReg;
            cp0Pkg::regBadVAddr: readValue = badVAddr;
            cp0Pkg::regEntryHi:  readValue = entryHi;
            cp0Pkg::regStatus:   readValue = status;
            cp0Pkg::regCause:    readValue = cause;
            cp0Pkg::regEpc:      readValue = epc;
            cp0Pkg::regPrid:     readValue = cp0Pkg::pridValue;
            cp0Pkg::regEbase:    readValue = ebase;
            cp0Pkg::regConfig:   readValue = configReg;
            cp0Pkg::regConfig1:  readValue = cp0Pkg::config1Reset;
            default:             readValue = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            indexReg   <= '0;
            randomReg  <= cp0Pkg::tlbIndexW'(cp0Pkg::tlbEntries - 1);
            contextReg <= '0;
            wiredReg   <= '0;
            entryHi    <= '0;
            status     <= cp0Pkg::statusReset;
            cause      <= '0;
            ebase      <= cp0Pkg::ebaseReset;
            configReg  <= cp0Pkg::configReset;
        end else begin
            // Random walks down to Wired then wraps to the top entry
            if (randomReg == wiredReg[cp0Pkg::tlbIndexW-1:0]) begin
                randomReg <= cp0Pkg::tlbIndexW'(cp0Pkg::tlbEntries - 1);
            end else begin
                randomReg <= randomReg - 1'b1;
            end
            if (writeEn) begin
                case (addr)
                    cp0Pkg::regIndex:
                        indexReg <= merge(indexReg, wdata, cp0Pkg::indexMask);
                    cp0Pkg::regContext:
                        contextReg <= merge(contextReg, wdata, cp0Pkg::contextMask);
                    cp0Pkg::regWired: begin
                        wiredReg  <= merge(wiredReg, wdata, cp0Pkg::wiredMask);
                        randomReg <= cp0Pkg::tlbIndexW'(cp0Pkg::tlbEntries - 1);
                    end
                    cp0Pkg::regEntryHi:
                        entryHi <= merge(entryHi, wdata, cp0Pkg::entryHiMask);
                    cp0Pkg::regStatus:
                        status <= merge(status, wdata, cp0Pkg::statusMask);
                    cp0Pkg::regCause:
                        cause <= merge(cause, wdata, cp0Pkg::causeMask);
                    cp0Pkg::regEbase:
                        ebase <= merge(ebase, wdata, cp0Pkg::ebaseMask);
                    cp0Pkg::regConfig:
                        configReg <= merge(configReg, wdata, cp0Pkg::configMask);
                    default: ;
                endcase
            end
            if (excEn) begin
                status[cp0Pkg::statusExl] <= 1'b1;
                cause[31]            <= excBd;
                cause[6:2]           <= excCode;
                entryHi[31:13]       <= excBadVAddr[31:13];
                contextReg[22:4]     <= excBadVAddr[31:13];  // BadVPN2
            end
            if (eretEn) begin
                status[cp0Pkg::statusExl] <= 1'b0;
            end
            if (tlbReadEn) begin
                entryHi <= {readEntry[85:67], 5'd0, readEntry[65:58]};
            end
            if (tlbProbeEn) begin
                indexReg <= {~probeHit, 28'd0, probeIndex};
            end
            cause[15:10] <= hint;  // IP7..IP2
        end
    end

    always_ff @(posedge clk) begin
        if (writeEn && addr == cp0Pkg::regEntryLo0) begin
            entryLo0 <= merge(entryLo0, wdata, cp0Pkg::entryLoMask);
        end
        if (writeEn && addr == cp0Pkg::regEntryLo1) begin
            entryLo1 <= merge(entryLo1, wdata, cp0Pkg::entryLoMask);
        end
        if (writeEn && addr == cp0Pkg::regEpc) begin
            epc <= wdata;
        end
        if (tlbReadEn) begin
            entryLo0 <= {2'd0, readEntry[57:29], readEntry[66]};
            entryLo1 <= {2'd0, readEntry[28:0], readEntry[66]};
        end
        if (excEn) begin
            epc      <= excEpc;
            badVAddr <= excBadVAddr;
        end
        // ERET, TLBP and exception entry report a fixed register
        if (eretEn) begin
            selAddr <= cp0Pkg::regEpc;
        end else if (tlbProbeEn) begin
            selAddr <= cp0Pkg::regIndex;
        end else if (excEn) begin
            selAddr <= cp0Pkg::regStatus;
        end else begin
            selAddr <= addr;
        end
        if (captureEn) begin
            rdata <= readValue;
        end
    end

endmodule

// File: rtl/cp0Top.sv
`timescale 1ns/10ps

module cp0Top (
    input  logic         clk,
    input  logic         rst,
    input  logic         req,
    input  cp0Pkg::cp0Op op,
    input  logic [7:0]   addr,
    input  logic [31:0]  wdata,
    input  logic [4:0]   excCode,
    input  logic [31:0]  excBadVAddr,
    input  logic         excBd,
    input  logic [31:0]  excEpc,
    input  logic [5:0]   hint,
    input  logic [31:0]  lookupVaddr,
    output logic         ack,
    output logic [31:0]  rdata,
    output logic [31:0]  lookupPaddr,
    output logic         lookupMiss,
    output logic         userMode,
    output logic         exlSet,
    output logic         interruptPending,
    output logic [31:0]  epcAddress,
    output logic [31:0]  ebaseAddress
);

    logic                         writeEn;
    logic                         excEn;
    logic                         eretEn;
    logic                         tlbReadEn;
    logic                         tlbProbeEn;
    logic                         tlbWriteEn;
    logic                         useRandom;
    logic                         captureEn;
    logic [cp0Pkg::tlbEntryW-1:0] entryOut;
    logic [cp0Pkg::tlbEntryW-1:0] readEntry;
    logic [cp0Pkg::tlbIndexW-1:0] writeIndex;
    logic [cp0Pkg::tlbIndexW-1:0] probeIndex;
    logic [7:0]                   asid;
    logic                         probeHit;

    cp0Control uControl (.*);

    cp0Regs uRegs (.*);

    // EntryHi/EntryLo pair is both the write data and the probe key
    jointTlb uTlb (
        .writeEntry(entryOut),
        .*
    );

endmodule

// File: rtl/jointTlb.sv
`timescale 1ns/10ps

module jointTlb (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           tlbWriteEn,
    input  logic [cp0Pkg::tlbIndexW-1:0]   writeIndex,
    input  logic [cp0Pkg::tlbEntryW-1:0]   writeEntry,
    input  logic [7:0]                     asid,
    input  logic [31:0]                    lookupVaddr,
    output logic [cp0Pkg::tlbEntryW-1:0]   readEntry,
    output logic                           probeHit,
    output logic [cp0Pkg::tlbIndexW-1:0]   probeIndex,
    output logic [31:0]                    lookupPaddr,
    output logic                           lookupMiss
);

    logic [cp0Pkg::tlbEntryW-1:0] entries [cp0Pkg::tlbEntries];
    logic [cp0Pkg::tlbEntries-1:0] valid;
    logic [cp0Pkg::tlbEntries-1:0] probeMatch;
    logic [cp0Pkg::tlbEntries-1:0] lookupMatch;
    logic [cp0Pkg::tlbIndexW-1:0]  lookupIndex;
    logic [28:0]                   page;   // PFN, C, D, V of the selected half

    // VPN2 in [85:67], G in [66], ASID in [65:58]
    function automatic logic entryMatch(input logic [cp0Pkg::tlbEntryW-1:0] entry,
                                        input logic [18:0] vpn2,
                                        input logic [7:0] asidIn);
        return entry[85:67] == vpn2 && (entry[66] || entry[65:58] == asidIn);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (tlbWriteEn) begin
            valid[writeIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbWriteEn) begin
            entries[writeIndex] <= writeEntry;
        end
    end

    assign readEntry = valid[writeIndex] ? entries[writeIndex] : '0;

    always_comb begin
        for (int i = 0; i < cp0Pkg::tlbEntries; i++) begin
            probeMatch[i]  = valid[i] && entryMatch(entries[i], writeEntry[85:67], asid);
            lookupMatch[i] = valid[i] && entryMatch(entries[i], lookupVaddr[31:13], asid);
        end
    end

    // Lowest matching entry wins
    always_comb begin
        probeIndex  = '0;
        lookupIndex = '0;
        for (int i = cp0Pkg::tlbEntries - 1; i >= 0; i--) begin
            if (probeMatch[i]) begin
                probeIndex = cp0Pkg::tlbIndexW'(i);
            end
            if (lookupMatch[i]) begin
                lookupIndex = cp0Pkg::tlbIndexW'(i);
            end
        end
    end

    assign probeHit = |probeMatch;

    // Bit 12 picks the odd page
    assign page        = lookupVaddr[12] ? entries[lookupIndex][28:0]
                                         : entries[lookupIndex][57:29];
    assign lookupMiss  = !(|lookupMatch) || !page[0];
    assign lookupPaddr = {page[24:5], lookupVaddr[11:0]};  // Low 20 bits of PFN

endmodule

// File: sim/cp0Input.txt
# name op addr wdata excCode excBadVAddr excBd excEpc lookupVaddr expected, all hex
# tlbpw: probe hit at or above expected; lookup: ffffffff is a miss; irq: expected is Status
rstStatus    mfc0   60 00000000 00 00000000 0 00000000 00000000 10400004
rstPrid      mfc0   78 00000000 00 00000000 0 00000000 00000000 00018000
rstConfig    mfc0   80 00000000 00 00000000 0 00000000 00000000 80000083
rstEbase     mfc0   79 00000000 00 00000000 0 00000000 00000000 80000000
maskStatus   mtc0   60 ffffffff 00 00000000 0 00000000 00000000 1040ff17
fixStatus    mtc0   60 10400004 00 00000000 0 00000000 00000000 10400004
maskEntryHi  mtc0   50 ffffffff 00 00000000 0 00000000 00000000 ffffe0ff
maskWired    mtc0   30 ffffffff 00 00000000 0 00000000 00000000 00000007
clearWired   mtc0   30 00000000 00 00000000 0 00000000 00000000 00000000
excEntry     exc    00 00000000 03 12345678 1 bfc00100 00000000 10400006
excExl       exl    00 00000000 00 00000000 0 00000000 00000000 00000001
excEpc       mfc0   70 00000000 00 00000000 0 00000000 00000000 bfc00100
excBadVAddr  mfc0   40 00000000 00 00000000 0 00000000 00000000 12345678
excCause     mfc0   68 00000000 00 00000000 0 00000000 00000000 8000000c
excContext   mfc0   20 00000000 00 00000000 0 00000000 00000000 00091a20
eretReturn   eret   00 00000000 00 00000000 0 00000000 00000000 bfc00100
eretExl      exl    00 00000000 00 00000000 0 00000000 00000000 00000000
setEntryHi   mtc0   50 00402011 00 00000000 0 00000000 00000000 00402011
setLo0       mtc0   10 00048d1e 00 00000000 0 00000000 00000000 00048d1e
setLo1       mtc0   18 00159e12 00 00000000 0 00000000 00000000 00159e12
setIndex     mtc0   00 00000002 00 00000000 0 00000000 00000000 00000002
tlbwiWrite   tlbwi  00 00000000 00 00000000 0 00000000 00000000 00000002
clrEntryHi   mtc0   50 00000000 00 00000000 0 00000000 00000000 00000000
clrLo0       mtc0   10 00000000 00 00000000 0 00000000 00000000 00000000
tlbrRead     tlbr   50 00000000 00 00000000 0 00000000 00000000 00402011
tlbrLo0      mfc0   10 00000000 00 00000000 0 00000000 00000000 00048d1e
setIndex5    mtc0   00 00000005 00 00000000 0 00000000 00000000 00000005
tlbpHit      tlbp   00 00000000 00 00000000 0 00000000 00000000 00000002
asidOther    mtc0   50 00402022 00 00000000 0 00000000 00000000 00402022
tlbpMiss     tlbp   00 00000000 00 00000000 0 00000000 00000000 80000000
asidBack     mtc0   50 00402011 00 00000000 0 00000000 00000000 00402011
lookEven     lookup 00 00000000 00 00000000 0 00000000 00402abc 01234abc
lookOdd      lookup 00 00000000 00 00000000 0 00000000 00403def 05678def
lookNoMatch  lookup 00 00000000 00 00000000 0 00000000 00802000 ffffffff
wired4       mtc0   30 00000004 00 00000000 0 00000000 00000000 00000004
setEntryHi2  mtc0   50 10000011 00 00000000 0 00000000 00000000 10000011
setLo0b      mtc0   10 00000000 00 00000000 0 00000000 00000000 00000000
setLo1b      mtc0   18 002af35e 00 00000000 0 00000000 00000000 002af35e
tlbwrWrite   tlbwr  30 00000000 00 00000000 0 00000000 00000000 00000004
tlbwrProbe   tlbpw  00 00000000 00 00000000 0 00000000 00000000 00000004
lookInvalid  lookup 00 00000000 00 00000000 0 00000000 10000123 ffffffff
lookValid    lookup 00 00000000 00 00000000 0 00000000 10001456 0abcd456
enableIrq    mtc0   60 1040fc01 00 00000000 0 00000000 00000000 1040fc01
irqFirst     irq    00 00000000 00 00000000 0 00000000 00000000 1040fc01
irqSecond    irq    00 00000000 00 00000000 0 00000000 00000000 1040fc01
irqThird     irq    00 00000000 00 00000000 0 00000000 00000000 1040fc01

// File: sim/cp0Tb.sv
`timescale 1ns/10ps

module cp0Tb;

    localparam int maxVectors = 64;

    logic         clk;
    logic         rst;
    logic         req;
    cp0Pkg::cp0Op op;
    logic [7:0]   addr;
    logic [31:0]  wdata;
    logic [4:0]   excCode;
    logic [31:0]  excBadVAddr;
    logic         excBd;
    logic [31:0]  excEpc;
    logic [5:0]   hint;
    logic [31:0]  lookupVaddr;
    logic         ack;
    logic [31:0]  rdata;
    logic [31:0]  lookupPaddr;
    logic         lookupMiss;
    logic         userMode;
    logic         exlSet;
    logic         interruptPending;
    logic [31:0]  epcAddress;
    logic [31:0]  ebaseAddress;

    string       names [maxVectors];
    string       ops [maxVectors];
    // addr, wdata, excCode, excBadVAddr, excBd, excEpc, lookupVaddr, expected
    logic [31:0] fields [maxVectors][8];
    int          numVectors;
    bit          loaded;
    int          errors;
    int          failedTests;
    bit          testFailed;
    integer      seed;

    cp0Top u_dut (.*);

    always #20 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            errors++;
            testFailed = 1'b1;
        end
    endtask

    function automatic cp0Pkg::cp0Op decodeOp(input string name);
        case (name)
            "mtc0":         return cp0Pkg::opMtc0;
            "tlbr":         return cp0Pkg::opTlbr;
            "tlbwi":        return cp0Pkg::opTlbwi;
            "tlbwr":        return cp0Pkg::opTlbwr;
            "tlbp", "tlbpw": return cp0Pkg::opTlbp;
            "exc":          return cp0Pkg::opExc;
            "eret":         return cp0Pkg::opEret;
            default:        return cp0Pkg::opMfc0;
        endcase
    endfunction

    task automatic loadVectors();
        int    fd;
        int    count;
        string line;
        fd = $fopen("sim/cp0Input.txt", "r");
        if (fd == 0) begin
            $display("cannot open vector file sim/cp0Input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && numVectors < maxVectors) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    count = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h",
                                    names[numVectors], ops[numVectors],
                                    fields[numVectors][0], fields[numVectors][1],
                                    fields[numVectors][2], fields[numVectors][3],
                                    fields[numVectors][4], fields[numVectors][5],
                                    fields[numVectors][6], fields[numVectors][7]);
                    if (count == 10) begin
                        numVectors++;
                    end else begin
                        $display("malformed vector line: %s", line);
                        errors++;
                    end
                end
            end
            if (numVectors == 0) begin
                $display("no vectors found in sim/cp0Input.txt");
                errors++;
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    // Full four-phase transfer with timing checks on ack
    task automatic runOp(input string name, input cp0Pkg::cp0Op code,
                         input logic [31:0] a, input logic [31:0] d,
                         input logic [31:0] ec, input logic [31:0] bva,
                         input logic [31:0] bd, input logic [31:0] ep,
                         output logic [31:0] result);
        int edges;
        @(posedge clk);
        req         <= 1'b1;
        op          <= code;
        addr        <= a[7:0];
        wdata       <= d;
        excCode     <= ec[4:0];
        excBadVAddr <= bva;
        excBd       <= bd[0];
        excEpc      <= ep;
        edges = 0;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
            edges++;
        end
        checkValue({name, " ack delay"}, 2, 32'(edges - 1));  // First edge only sees req
        result = rdata;
        repeat (2) begin
            @(negedge clk);
            checkValue({name, " ack hold"}, 1, {31'd0, ack});
            checkValue({name, " rdata hold"}, result, rdata);
        end
        @(posedge clk);
        req <= 1'b0;
        edges = 0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
            edges++;
        end
        checkValue({name, " ack release"}, 1, 32'(edges));
    endtask

    // Side outputs that mirror Status, EPC and EBase
    task automatic checkOutputs(input int i);
        logic        regOp;
        logic [7:0]  a;
        logic [31:0] expected;
        regOp    = ops[i] == "mfc0" || ops[i] == "mtc0";
        a        = fields[i][0][7:0];
        expected = fields[i][7];
        if (ops[i] == "exc" || (regOp && a == cp0Pkg::regStatus)) begin
            // User mode needs UM with ERL and EXL both clear
            checkValue({names[i], " userMode"},
                       {31'd0, expected[4] && !expected[2] && !expected[1]},
                       {31'd0, userMode});
        end
        if (ops[i] == "exc") begin
            checkValue({names[i], " epcAddress"}, fields[i][5], epcAddress);
        end
        if (ops[i] == "eret" || (regOp && a == cp0Pkg::regEpc)) begin
            checkValue({names[i], " epcAddress"}, expected, epcAddress);
        end
        if (regOp && a == cp0Pkg::regEbase) begin
            checkValue({names[i], " ebaseAddress"}, expected, ebaseAddress);
        end
    endtask

    task automatic runVector(input int i);
        logic [31:0] result;
        logic [5:0]  hintVal;
        logic        expectIrq;
        testFailed = 1'b0;
        if (ops[i] == "lookup") begin
            @(posedge clk);
            lookupVaddr <= fields[i][6];
            @(negedge clk);
            checkValue(names[i], fields[i][7], lookupMiss ? 32'hffff_ffff : lookupPaddr);
        end else if (ops[i] == "exl") begin
            @(negedge clk);
            checkValue(names[i], fields[i][7], {31'd0, exlSet});
        end else if (ops[i] == "irq") begin
            hintVal = 6'($random(seed));
            @(posedge clk);
            hint <= hintVal;
            @(posedge clk);  // Cause.IP takes the hint here
            @(negedge clk);
            expectIrq = fields[i][7][0] && !fields[i][7][1]
                        && |(fields[i][7][15:10] & hintVal);
            checkValue({names[i], " pending"}, {31'd0, expectIrq}, {31'd0, interruptPending});
            runOp(names[i], cp0Pkg::opMfc0, {24'd0, cp0Pkg::regCause}, 0, 0, 0, 0, 0, result);
            checkValue({names[i], " cause ip"}, {26'd0, hintVal}, {26'd0, result[15:10]});
        end else begin
            runOp(names[i], decodeOp(ops[i]), fields[i][0], fields[i][1], fields[i][2],
                  fields[i][3], fields[i][4], fields[i][5], result);
            if (ops[i] == "tlbpw") begin
                // Hit somewhere at or above Wired
                checkValue(names[i], 1, {31'd0, !result[31] && result[2:0] >= fields[i][7][2:0]});
            end else begin
                checkValue(names[i], fields[i][7], result);
            end
            checkOutputs(i);
        end
        if (testFailed) begin
            failedTests++;
            $display("test %s failed", names[i]);
        end else begin
            $display("test %s passed", names[i]);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        req         = 1'b0;
        op          = cp0Pkg::opMfc0;
        addr        = '0;
        wdata       = '0;
        excCode     = '0;
        excBadVAddr = '0;
        excBd       = 1'b0;
        excEpc      = '0;
        hint        = '0;
        lookupVaddr = '0;
        seed        = 32'h22f9b2ae;
        numVectors  = 0;
        loaded      = 1'b0;
        errors      = 0;
        failedTests = 0;
        testFailed  = 1'b0;
        loadVectors();
        if (errors == 0) begin
            repeat (5) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < numVectors; i++) begin
                runVector(i);
            end
        end
        $display("tests %0d, failed %0d, check errors %0d", numVectors, failedTests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Ten clock periods per vector plus room for reset
    initial begin
        wait (loaded);
        #((numVectors + 2) * 10 * 40);
        $display("timeout waiting for ack");
        $display("=== FAIL ===");
        $finish;
    end

endmodule
